/* hw/q_routing_pkg.sv */
package q_routing_pkg;

    // data widths
    localparam int word_width = 16;
    localparam int byte_width = 8;
    localparam int addr_width = 11;

    // table size in bytes
    localparam int mem_depth = 2048;

    // table address map, 16-bit little-endian words at even addresses
    localparam logic [addr_width-1:0] addr_neighbor_count = 11'h2C4;
    localparam logic [addr_width-1:0] addr_neighbor_id    = 11'h072;  // id per index
    localparam logic [addr_width-1:0] addr_neighbor_hops  = 11'h132;  // hop count per index
    localparam logic [addr_width-1:0] addr_neighbor_q     = 11'h172;  // q value per index
    localparam logic [addr_width-1:0] addr_best_list      = 11'h2B2;  // qualifying ids
    localparam logic [addr_width-1:0] addr_best_count     = 11'h2C8;  // length of list

    // length of the q value area
    localparam int max_neighbors = 32;

    // list slots between addr_best_list and addr_neighbor_count
    localparam int max_best = 9;

endpackage

/* hw/node_table_mem.sv */
`timescale 1ns/1ps

module node_table_mem (
    input  logic                                   clock,
    input  logic                                   nrst,
    input  logic [q_routing_pkg::addr_width-1:0]   host_addr,
    input  logic [q_routing_pkg::byte_width-1:0]   host_wdata,
    input  logic                                   host_we,
    output logic [q_routing_pkg::byte_width-1:0]   host_rdata,
    input  logic [q_routing_pkg::addr_width-1:0]   eng_addr,
    input  logic [q_routing_pkg::word_width-1:0]   eng_wdata,
    input  logic                                   eng_we,
    output logic [q_routing_pkg::word_width-1:0]   eng_rdata
);

    logic [q_routing_pkg::byte_width-1:0] mem [0:q_routing_pkg::mem_depth-1];

    logic [q_routing_pkg::addr_width-1:0] eng_addr_hi;  // upper byte of the word

    assign eng_addr_hi = eng_addr + 1'b1;

    // storage, both paths write at the edge
    always_ff @(posedge clock) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        if (eng_we) begin
            mem[eng_addr]    <= eng_wdata[q_routing_pkg::byte_width-1:0];  // low byte first
            mem[eng_addr_hi] <= eng_wdata[q_routing_pkg::word_width-1:q_routing_pkg::byte_width];
        end
    end

    // registered read ports
    always_ff @(posedge clock) begin
        if (!nrst) begin
            host_rdata <= '0;
            eng_rdata  <= '0;
        end else begin
            host_rdata <= mem[host_addr];
            eng_rdata  <= {mem[eng_addr_hi], mem[eng_addr]};  // little-endian word
        end
    end

endmodule

/* hw/best_neighbors.sv */
`timescale 1ns/1ps

module best_neighbors #(
    parameter int best_limit = q_routing_pkg::max_best
) (
    input  logic                                   clock,
    input  logic                                   nrst,
    input  logic                                   en,
    input  logic                                   start,
    input  logic [q_routing_pkg::word_width-1:0]   my_best_q,
    input  logic [q_routing_pkg::word_width-1:0]   eng_rdata,
    output logic [q_routing_pkg::addr_width-1:0]   eng_addr,
    output logic [q_routing_pkg::word_width-1:0]   eng_wdata,
    output logic                                   eng_we,
    output logic                                   done,
    output logic                                   busy,
    output logic [q_routing_pkg::word_width-1:0]   best_hop,
    output logic [q_routing_pkg::word_width-1:0]   best_neighbor_id,
    output logic [q_routing_pkg::word_width-1:0]   best_q_value,
    output logic [q_routing_pkg::word_width-1:0]   best_count
);

    localparam int idx_width  = $clog2(q_routing_pkg::max_neighbors + 1);
    localparam int list_width = $clog2(best_limit + 1);

    localparam logic [3:0] s_wait        = 4'd0;
    localparam logic [3:0] s_fetch_count = 4'd1;
    localparam logic [3:0] s_fetch_id    = 4'd2;
    localparam logic [3:0] s_fetch_hops  = 4'd3;
    localparam logic [3:0] s_fetch_q     = 4'd4;
    localparam logic [3:0] s_compare     = 4'd5;
    localparam logic [3:0] s_write_entry = 4'd6;
    localparam logic [3:0] s_write_count = 4'd7;
    localparam logic [3:0] s_finish      = 4'd8;

    logic [3:0]                             state;
    logic [idx_width-1:0]                   idx;
    logic [idx_width-1:0]                   idx_next;
    logic [idx_width-1:0]                   n_count;
    logic [idx_width-1:0]                   count_clamped;
    logic [list_width-1:0]                  list_count;
    logic [q_routing_pkg::addr_width-1:0]   idx_off;
    logic [q_routing_pkg::addr_width-1:0]   list_off;
    logic [q_routing_pkg::word_width-1:0]   cur_id;
    logic [q_routing_pkg::word_width-1:0]   cur_hops;
    logic [q_routing_pkg::word_width-1:0]   run_hop;
    logic [q_routing_pkg::word_width-1:0]   run_id;
    logic [q_routing_pkg::word_width-1:0]   run_q;
    logic                                   accept;
    logic                                   last;
    logic                                   qualify;
    logic                                   better;

    assign accept   = (state == s_wait) && en && start && !busy;
    assign idx_next = idx + 1'b1;
    assign last     = (idx_next == n_count);
    assign idx_off  = q_routing_pkg::addr_width'({idx, 1'b0});       // word stride
    assign list_off = q_routing_pkg::addr_width'({list_count, 1'b0});

    // count word from the table, limited to the q value area
    assign count_clamped = (eng_rdata > q_routing_pkg::max_neighbors) ?
                           idx_width'(q_routing_pkg::max_neighbors) :
                           eng_rdata[idx_width-1:0];

    // eng_rdata holds the q value while in compare
    assign qualify = (eng_rdata >= my_best_q) && (list_count < best_limit);
    assign better  = (idx == '0) || (eng_rdata > run_q) ||
                     ((eng_rdata == run_q) && (cur_hops < run_hop));  // lower index wins ties

    // address presented in the state, data returns in the next one
    always_comb begin
        case (state)
            s_fetch_count: eng_addr = q_routing_pkg::addr_neighbor_count;
            s_fetch_id:    eng_addr = q_routing_pkg::addr_neighbor_id + idx_off;
            s_fetch_hops:  eng_addr = q_routing_pkg::addr_neighbor_hops + idx_off;
            s_fetch_q:     eng_addr = q_routing_pkg::addr_neighbor_q + idx_off;
            s_write_entry: eng_addr = q_routing_pkg::addr_best_list + list_off;
            s_write_count: eng_addr = q_routing_pkg::addr_best_count;
            default:       eng_addr = '0;
        endcase
    end

    always_comb begin
        case (state)
            s_write_entry: eng_wdata = cur_id;
            s_write_count: eng_wdata = q_routing_pkg::word_width'(list_count);  // already bumped
            default:       eng_wdata = '0;
        endcase
    end

    assign eng_we = (state == s_write_entry) || (state == s_write_count);

    // neighbor capture and running best
    always_ff @(posedge clock) begin
        if (accept) begin
            run_hop <= '0;
            run_id  <= '0;
            run_q   <= '0;
        end
        if (state == s_fetch_hops) begin
            cur_id <= eng_rdata;
        end
        if (state == s_fetch_q) begin
            cur_hops <= eng_rdata;
        end
        if ((state == s_compare) && better) begin
            run_hop <= cur_hops;
            run_id  <= cur_id;
            run_q   <= eng_rdata;
        end
    end

    always_ff @(posedge clock) begin
        if (!nrst) begin
            state            <= s_wait;
            idx              <= '0;
            n_count          <= '0;
            list_count       <= '0;
            done             <= 1'b0;
            busy             <= 1'b0;
            best_hop         <= '0;
            best_neighbor_id <= '0;
            best_q_value     <= '0;
            best_count       <= '0;
        end else begin
            case (state)
                s_wait: begin
                    done <= 1'b0;
                    if (accept) begin
                        busy       <= 1'b1;
                        idx        <= '0;
                        list_count <= '0;
                        state      <= s_fetch_count;
                    end else begin
                        busy <= 1'b0;  // drops after the done cycle
                    end
                end
                s_fetch_count: state <= s_fetch_id;
                s_fetch_id: begin
                    if (idx == '0) begin  // count word arrives on first visit only
                        n_count <= count_clamped;
                        state   <= (count_clamped == '0) ? s_finish : s_fetch_hops;
                    end else begin
                        state <= s_fetch_hops;
                    end
                end
                s_fetch_hops: state <= s_fetch_q;
                s_fetch_q:    state <= s_compare;
                s_compare: begin
                    if (qualify) begin
                        state <= s_write_entry;
                    end else if (last) begin
                        state <= s_finish;
                    end else begin
                        idx   <= idx_next;
                        state <= s_fetch_id;
                    end
                end
                s_write_entry: begin
                    list_count <= list_count + 1'b1;
                    state      <= s_write_count;
                end
                s_write_count: begin
                    if (last) begin
                        state <= s_finish;
                    end else begin
                        idx   <= idx_next;
                        state <= s_fetch_id;
                    end
                end
                s_finish: begin
                    done             <= 1'b1;
                    best_hop         <= run_hop;
                    best_neighbor_id <= run_id;
                    best_q_value     <= run_q;
                    best_count       <= q_routing_pkg::word_width'(list_count);
                    state            <= s_wait;
                end
                default: state <= s_wait;
            endcase
        end
    end

endmodule

/* hw/q_routing_node.sv */
`timescale 1ns/1ps

module q_routing_node #(
    parameter int best_limit = q_routing_pkg::max_best
) (
    input  logic                                   clock,
    input  logic                                   nrst,
    input  logic [q_routing_pkg::addr_width-1:0]   host_addr,
    input  logic [q_routing_pkg::byte_width-1:0]   host_wdata,
    input  logic                                   host_we,
    output logic [q_routing_pkg::byte_width-1:0]   host_rdata,
    input  logic                                   en,
    input  logic                                   start,
    input  logic [q_routing_pkg::word_width-1:0]   my_best_q,
    output logic                                   done,
    output logic                                   busy,
    output logic [q_routing_pkg::word_width-1:0]   best_hop,
    output logic [q_routing_pkg::word_width-1:0]   best_neighbor_id,
    output logic [q_routing_pkg::word_width-1:0]   best_q_value,
    output logic [q_routing_pkg::word_width-1:0]   best_count
);

    logic [q_routing_pkg::addr_width-1:0] eng_addr;
    logic [q_routing_pkg::word_width-1:0] eng_wdata;
    logic [q_routing_pkg::word_width-1:0] eng_rdata;
    logic                                 eng_we;
    logic                                 host_we_gated;

    // table is owned by the engine during a scan
    assign host_we_gated = host_we && !busy;

    node_table_mem u_mem (
        .clock      (clock),
        .nrst       (nrst),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we_gated),
        .host_rdata (host_rdata),
        .eng_addr   (eng_addr),
        .eng_wdata  (eng_wdata),
        .eng_we     (eng_we),
        .eng_rdata  (eng_rdata)
    );

    best_neighbors #(
        .best_limit (best_limit)
    ) u_engine (
        .clock            (clock),
        .nrst             (nrst),
        .en               (en),
        .start            (start),
        .my_best_q        (my_best_q),
        .eng_rdata        (eng_rdata),
        .eng_addr         (eng_addr),
        .eng_wdata        (eng_wdata),
        .eng_we           (eng_we),
        .done             (done),
        .busy             (busy),
        .best_hop         (best_hop),
        .best_neighbor_id (best_neighbor_id),
        .best_q_value     (best_q_value),
        .best_count       (best_count)
    );

endmodule

/* verif/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_word(input logic [q_routing_pkg::word_width-1:0] got,
                          input logic [q_routing_pkg::word_width-1:0] exp,
                          input string what);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_byte(input logic [q_routing_pkg::byte_width-1:0] got,
                          input logic [q_routing_pkg::byte_width-1:0] exp,
                          input string what);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

function automatic logic [q_routing_pkg::addr_width-1:0] word_addr(
    input logic [q_routing_pkg::addr_width-1:0] base, input int index);
    return base + q_routing_pkg::addr_width'(2 * index);  // 16-bit word stride
endfunction

task automatic write_byte(input logic [q_routing_pkg::addr_width-1:0] addr,
                          input logic [q_routing_pkg::byte_width-1:0] data);
    @(posedge clock);
    host_addr  <= addr;
    host_wdata <= data;
    host_we    <= 1'b1;
    @(posedge clock);
    host_we <= 1'b0;
endtask

task automatic write_word(input logic [q_routing_pkg::addr_width-1:0] addr,
                          input logic [q_routing_pkg::word_width-1:0] data);
    write_byte(addr, data[7:0]);  // little-endian
    write_byte(addr + 1'b1, data[15:8]);
endtask

task automatic read_byte(input logic [q_routing_pkg::addr_width-1:0] addr,
                         output logic [q_routing_pkg::byte_width-1:0] data);
    @(posedge clock);
    host_addr <= addr;
    @(posedge clock);
    @(negedge clock);  // one cycle read latency
    data = host_rdata;
endtask

task automatic load_neighbors(input int n);
    write_word(q_routing_pkg::addr_neighbor_count, q_routing_pkg::word_width'(n));
    for (int i = 0; i < n; i++) begin
        write_word(word_addr(q_routing_pkg::addr_neighbor_id, i), nb_id[i]);
        write_word(word_addr(q_routing_pkg::addr_neighbor_hops, i), nb_hops[i]);
        write_word(word_addr(q_routing_pkg::addr_neighbor_q, i), nb_q[i]);
    end
endtask

// qualifying list in index order and the highest q
task automatic compute_expected(input int n, input logic [q_routing_pkg::word_width-1:0] my_q);
    int pick;
    exp_count = 0;
    exp_hop   = '0;
    exp_id    = '0;
    exp_q     = '0;
    pick      = -1;
    for (int i = 0; i < n; i++) begin
        if ((nb_q[i] >= my_q) && (exp_count < best_limit)) begin
            exp_list[exp_count] = nb_id[i];
            exp_count++;
        end
        if (nb_q[i] > exp_q) begin
            exp_q = nb_q[i];
        end
    end
    // fewest hops among the top q and the lower index on a hop tie
    for (int i = 0; i < n; i++) begin
        if ((nb_q[i] == exp_q) && ((pick < 0) || (nb_hops[i] < nb_hops[pick]))) begin
            pick = i;
        end
    end
    if (pick >= 0) begin
        exp_hop = nb_hops[pick];
        exp_id  = nb_id[pick];
    end
endtask

task automatic pulse_start(input logic [q_routing_pkg::word_width-1:0] my_q);
    @(posedge clock);
    en        <= 1'b1;
    my_best_q <= my_q;
    start     <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
endtask

task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!done && (cycles < done_timeout)) begin
        @(negedge clock);
        cycles++;
    end
    if (!done) begin
        timeouts++;
        $display("Timeout at %0t ns: done never arrived in %0d cycles", $time, done_timeout);
    end
endtask

task automatic wait_busy();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!busy && (cycles < busy_timeout)) begin
        @(negedge clock);
        cycles++;
    end
    if (!busy) begin
        timeouts++;
        $display("Timeout at %0t ns: busy never went high after start", $time);
    end
endtask

task automatic compare_results();
    check_word(best_hop, exp_hop, "best_hop");
    check_word(best_neighbor_id, exp_id, "best_neighbor_id");
    check_word(best_q_value, exp_q, "best_q_value");
    check_word(best_count, q_routing_pkg::word_width'(exp_count), "best_count");
endtask

task automatic read_back_list();
    logic [q_routing_pkg::byte_width-1:0] data;
    logic [q_routing_pkg::addr_width-1:0] addr;
    for (int i = 0; i < exp_count; i++) begin
        addr = word_addr(q_routing_pkg::addr_best_list, i);
        read_byte(addr, data);
        check_byte(data, exp_list[i][7:0], $sformatf("list entry %0d low byte", i));
        read_byte(addr + 1'b1, data);
        check_byte(data, exp_list[i][15:8], $sformatf("list entry %0d high byte", i));
    end
    read_byte(q_routing_pkg::addr_best_count, data);
    check_byte(data, q_routing_pkg::byte_width'(exp_count), "list count low byte");
    read_byte(q_routing_pkg::addr_best_count + 1'b1, data);
    check_byte(data, 8'h00, "list count high byte");
endtask

task automatic reset_values_zero();
    @(negedge clock);
    compare_flag(done, 1'b0, "done after reset");
    compare_flag(busy, 1'b0, "busy after reset");
    check_word(best_hop, '0, "best_hop after reset");
    check_word(best_neighbor_id, '0, "best_neighbor_id after reset");
    check_word(best_q_value, '0, "best_q_value after reset");
    check_word(best_count, '0, "best_count after reset");
endtask

task automatic two_neighbors_qualify();
    for (int i = 0; i < 5; i++) begin
        nb_id[i]   = 16'h1100 + 16'(i);
        nb_hops[i] = 16'(i + 1);
        nb_q[i]    = 16'h0100 + 16'(i * 64);
    end
    nb_q[1] = 16'h0900;  // qualifies
    nb_q[3] = 16'h0C00;  // qualifies and is the overall best
    load_neighbors(5);
    pulse_start(16'h0800);
    wait_done();
    compute_expected(5, 16'h0800);
    compare_results();
    check_word(best_count, 16'd2, "best_count with two qualifying");
    read_back_list();
endtask

task automatic random_table_best();
    for (int i = 0; i < 20; i++) begin
        nb_id[i]   = 16'h2000 + 16'(i * 3);
        nb_hops[i] = 16'($random(seed)) & 16'h001F;
        nb_q[i]    = 16'($random(seed)) & 16'h7FFF;  // keeps the planted tie on top
    end
    nb_q[6]     = 16'hFFFF;
    nb_hops[6]  = 16'd9;
    nb_q[13]    = 16'hFFFF;
    nb_hops[13] = 16'd4;  // same q with fewer hops
    load_neighbors(20);
    pulse_start(16'h6000);
    wait_done();
    compute_expected(20, 16'h6000);
    compare_results();
    check_word(best_neighbor_id, nb_id[13], "tie winner id");
    read_back_list();
endtask

task automatic list_limit_respected();
    logic [q_routing_pkg::byte_width-1:0] data;
    for (int i = 0; i < 12; i++) begin
        nb_id[i]   = 16'h3000 + 16'(i);
        nb_hops[i] = 16'd2;
        nb_q[i]    = 16'h3000 + 16'(i * 256);
    end
    load_neighbors(12);
    pulse_start(16'h1000);
    wait_done();
    compute_expected(12, 16'h1000);
    compare_results();
    check_word(best_count, 16'(best_limit), "best_count at list limit");
    read_back_list();
    read_byte(q_routing_pkg::addr_neighbor_count, data);  // slot past the list
    check_byte(data, 8'd12, "neighbor count after full list");
endtask

task automatic zero_neighbor_count();
    logic [q_routing_pkg::byte_width-1:0] data;
    write_word(q_routing_pkg::addr_neighbor_count, 16'h0000);
    write_word(q_routing_pkg::addr_best_count, 16'h5A3C);
    pulse_start(16'h0000);
    wait_done();
    check_word(best_hop, '0, "best_hop with no neighbors");
    check_word(best_neighbor_id, '0, "best_neighbor_id with no neighbors");
    check_word(best_q_value, '0, "best_q_value with no neighbors");
    check_word(best_count, '0, "best_count with no neighbors");
    read_byte(q_routing_pkg::addr_best_count, data);
    check_byte(data, 8'h3C, "untouched list count low byte");
    read_byte(q_routing_pkg::addr_best_count + 1'b1, data);
    check_byte(data, 8'h5A, "untouched list count high byte");
endtask

task automatic host_write_blocked();
    logic [q_routing_pkg::addr_width-1:0] targets [0:2];
    logic [q_routing_pkg::byte_width-1:0] data;
    for (int i = 0; i < 6; i++) begin
        nb_id[i]   = 16'h3300 + 16'(i);
        nb_hops[i] = 16'(7 - i);
        nb_q[i]    = 16'h0500;  // all tied on q
    end
    targets[0] = q_routing_pkg::addr_neighbor_id;
    targets[1] = word_addr(q_routing_pkg::addr_neighbor_hops, 2);
    targets[2] = word_addr(q_routing_pkg::addr_neighbor_q, 5) + 1'b1;
    load_neighbors(6);
    pulse_start(16'h0400);
    wait_busy();
    for (int i = 0; i < 3; i++) begin
        @(posedge clock);
        host_addr  <= targets[i];
        host_wdata <= 8'hEE;
        host_we    <= 1'b1;
    end
    @(posedge clock);
    host_we <= 1'b0;
    @(negedge clock);
    compare_flag(busy, 1'b1, "busy during host writes");
    wait_done();
    compute_expected(6, 16'h0400);
    compare_results();
    read_byte(targets[0], data);
    check_byte(data, nb_id[0][7:0], "id 0 low byte after blocked write");
    read_byte(targets[1], data);
    check_byte(data, nb_hops[2][7:0], "hops 2 low byte after blocked write");
    read_byte(targets[2], data);
    check_byte(data, nb_q[5][15:8], "q 5 high byte after blocked write");
endtask

`endif

/* verif/tb_q_routing_node.sv */
`timescale 1ns/1ps

module tb_q_routing_node;

    localparam int best_limit   = q_routing_pkg::max_best;
    localparam int done_timeout = 2000;  // cycles
    localparam int busy_timeout = 20;

    logic                                 clock;
    logic                                 nrst;
    logic [q_routing_pkg::addr_width-1:0] host_addr;
    logic [q_routing_pkg::byte_width-1:0] host_wdata;
    logic                                 host_we;
    logic [q_routing_pkg::byte_width-1:0] host_rdata;
    logic                                 en;
    logic                                 start;
    logic [q_routing_pkg::word_width-1:0] my_best_q;
    logic                                 done;
    logic                                 busy;
    logic [q_routing_pkg::word_width-1:0] best_hop;
    logic [q_routing_pkg::word_width-1:0] best_neighbor_id;
    logic [q_routing_pkg::word_width-1:0] best_q_value;
    logic [q_routing_pkg::word_width-1:0] best_count;

    // image of the neighbor area as loaded into the table
    logic [q_routing_pkg::word_width-1:0] nb_id    [0:q_routing_pkg::max_neighbors-1];
    logic [q_routing_pkg::word_width-1:0] nb_hops  [0:q_routing_pkg::max_neighbors-1];
    logic [q_routing_pkg::word_width-1:0] nb_q     [0:q_routing_pkg::max_neighbors-1];

    // reference model results
    logic [q_routing_pkg::word_width-1:0] exp_list [0:q_routing_pkg::max_best-1];
    logic [q_routing_pkg::word_width-1:0] exp_hop;
    logic [q_routing_pkg::word_width-1:0] exp_id;
    logic [q_routing_pkg::word_width-1:0] exp_q;
    int                                   exp_count;

    int                                   errors;
    int                                   timeouts;
    integer                               seed;

    always #2 clock = ~clock;  // 4 ns period

    q_routing_node #(
        .best_limit (best_limit)
    ) u_dut (
        .clock            (clock),
        .nrst             (nrst),
        .host_addr        (host_addr),
        .host_wdata       (host_wdata),
        .host_we          (host_we),
        .host_rdata       (host_rdata),
        .en               (en),
        .start            (start),
        .my_best_q        (my_best_q),
        .done             (done),
        .busy             (busy),
        .best_hop         (best_hop),
        .best_neighbor_id (best_neighbor_id),
        .best_q_value     (best_q_value),
        .best_count       (best_count)
    );

    `include "tb_tasks.svh"

    initial begin
        clock      = 1'b0;
        nrst       = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_we    = 1'b0;
        en         = 1'b0;
        start      = 1'b0;
        my_best_q  = '0;
        errors     = 0;
        timeouts   = 0;
        seed       = 32'h2bf6;

        repeat (5) @(posedge clock);
        nrst <= 1'b1;

        reset_values_zero();
        two_neighbors_qualify();
        random_table_best();
        list_limit_respected();
        zero_neighbor_count();
        host_write_blocked();

        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* q_routing_node.f */
+incdir+verif
hw/q_routing_pkg.sv
hw/node_table_mem.sv
hw/best_neighbors.sv
hw/q_routing_node.sv
verif/tb_q_routing_node.sv

/* run_sim.sh */
#!/bin/sh
# build and run the q_routing_node testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_q_routing_node \
    -f q_routing_node.f -o tb_q_routing_node
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_q_routing_node > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q ">>> FAIL" "$log"; then
    echo "testbench reported failure"
    exit 1
fi
exit 0
